// ==== uart_rx_array.f ====
src/uart_rx_pkg.sv
src/rx_line_sync.sv
src/uart_rx.sv
src/rx_axil_regs.sv
src/uart_rx_array.sv
bench/uart_rx_array_props.sv
bench/uart_rx_array_checker.sv
bench/uart_rx_array_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module uart_rx_array_tb \
  -f uart_rx_array.f -o uart_rx_array_sim &&
  ./obj_dir/uart_rx_array_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== bench/uart_rx_cases.txt ====
# op ch data stop frames, data in hex is the last byte sent on the line
# op 0 send then read, 1 send then write then read, 2 send together with neighbouring 2s then read
0 0 a5 1 1
0 1 3c 1 1
0 2 00 1 1
0 3 ff 1 1
0 1 5a 0 1
0 1 5a 1 0
0 2 81 1 2
0 2 00 1 0
0 3 7e 0 3
1 3 00 1 0
1 0 c3 0 1
2 0 11 1 1
2 1 22 0 1
2 2 33 1 2
2 3 44 1 1
0 3 44 1 0
2 0 e7 1 3
2 3 09 0 2
0 0 00 1 0

// ==== bench/uart_rx_array_tb.sv ====
// testbench top; plays the case file as serial frames and axi4-lite accesses, then reports the result
`timescale 1ns/100ps

module uart_rx_array_tb;

  // pin start edge to readable status word
  localparam int LAT_BOUND  = 3 + uart_rx_pkg::WAIT_DIV / 2 + 9 * uart_rx_pkg::WAIT_DIV + 2;
  localparam int RST_CYCLES = 10;

  logic                   clk;
  logic                   rst;
  logic                   rxd [uart_rx_pkg::NUM_CH];
  uart_rx_pkg::axil_req_t axil_req;
  uart_rx_pkg::axil_rsp_t axil_rsp;

  int seed = 32'hc634_d522;
  int cycles = 0;
  int limit = 32'h7fff_ffff;
  int ready_at = 0;
  int busy = 0;
  int n_cases = 0;
  bit load_ok = 1'b0;
  int c_op [$];
  int c_ch [$];
  int c_data [$];
  int c_stop [$];
  int c_n [$];

  uart_rx_array i_uart_rx_array (
    .clk      (clk),
    .rst      (rst),
    .rxd      (rxd),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  uart_rx_array_checker i_checker (
    .clk      (clk),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  bind uart_rx_array uart_rx_array_props i_uart_rx_array_props (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog, limit set once the cases are known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic load_cases();
    int fd;
    int op, ch, d, st, n;
    string line;
    fd = $fopen("bench/uart_rx_cases.txt", "r");
    load_ok = (fd != 0);
    if (load_ok) begin
      limit = RST_CYCLES;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ($sscanf(line, "%d %d %h %d %d", op, ch, d, st, n) == 5) begin
          c_op.push_back(op);
          c_ch.push_back(ch);
          c_data.push_back(d);
          c_stop.push_back(st);
          c_n.push_back(n);
          limit += n * 10 * uart_rx_pkg::WAIT_DIV + 100;
        end
      end
      $fclose(fd);
      n_cases = c_op.size();
    end
  endtask

  task automatic drive_bit(input int ch, input logic v);
    @(negedge clk);
    rxd[ch] = v;
    repeat (uart_rx_pkg::WAIT_DIV - 1) @(negedge clk);
  endtask

  task automatic send_frames(input int ch, input int last, input logic stop, input int n);
    uart_rx_pkg::uart_byte_t b;
    int gap;
    for (int k = 0; k < n; k++) begin
      // earlier frames count up to the listed byte
      b = uart_rx_pkg::uart_byte_t'(last - (n - 1 - k));
      drive_bit(ch, 1'b0);
      if (cycles - uart_rx_pkg::WAIT_DIV + 1 + LAT_BOUND > ready_at) begin
        ready_at = cycles - uart_rx_pkg::WAIT_DIV + 1 + LAT_BOUND;
      end
      for (int i = 0; i < 8; i++) begin
        drive_bit(ch, b[i]);
      end
      drive_bit(ch, stop);
      gap = 2 + int'($unsigned($random(seed)) % 14);
      @(negedge clk);
      rxd[ch] = 1'b1;
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic read_channel(input int ch);
    int delay;
    delay = int'($unsigned($random(seed)) % 4);
    @(negedge clk);
    axil_req.araddr  = uart_rx_pkg::axil_addr_t'(ch * uart_rx_pkg::REG_STRIDE);
    axil_req.arvalid = 1'b1;
    // arready depends only on the read fsm, settled by now
    while (!axil_rsp.arready) @(negedge clk);
    @(negedge clk);
    axil_req.arvalid = 1'b0;
    repeat (delay) @(negedge clk);
    axil_req.rready = 1'b1;
    while (!axil_rsp.rvalid) @(negedge clk);
    @(negedge clk);
    axil_req.rready = 1'b0;
  endtask

  task automatic write_channel(input int ch);
    @(negedge clk);
    axil_req.awaddr  = uart_rx_pkg::axil_addr_t'(ch * uart_rx_pkg::REG_STRIDE);
    axil_req.awvalid = 1'b1;
    // looks like a full status word, must not land
    axil_req.wdata   = 32'h0000_07ff;
    axil_req.wstrb   = 4'hf;
    axil_req.wvalid  = 1'b1;
    while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge clk);
    @(negedge clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    while (!axil_rsp.bvalid) @(negedge clk);
    @(negedge clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic run_cases();
    int i;
    int j;
    i = 0;
    while (i < n_cases) begin
      // consecutive op 2 lines form one burst on several channels
      j = i + 1;
      while (c_op[i] == 2 && j < n_cases && c_op[j] == 2) begin
        j++;
      end
      for (int k = i; k < j; k++) begin
        automatic int q = k;
        busy++;
        fork
          begin
            send_frames(c_ch[q], c_data[q], c_stop[q] != 0, c_n[q]);
            busy--;
          end
        join_none
      end
      wait (busy == 0);
      while (cycles < ready_at) @(negedge clk);
      for (int k = i; k < j; k++) begin
        if (c_op[k] == 1) begin
          write_channel(c_ch[k]);
        end
        read_channel(c_ch[k]);
      end
      i = j;
    end
  endtask

  task automatic report_result();
    int tests;
    int errors;
    int prop_fails;
    tests      = i_checker.n_tests;
    errors     = i_checker.n_errors;
    prop_fails = i_uart_rx_array.i_uart_rx_array_props.n_fail;
    if (tests != n_cases) begin
      $display("only %0d of %0d reads were checked", tests, n_cases);
    end
    $display("tests %0d of %0d, errors %0d, assertion failures %0d",
             tests, n_cases, errors, prop_fails);
    if (load_ok && errors == 0 && prop_fails == 0 && tests == n_cases) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    rst      = 1'b1;
    axil_req = '0;
    for (int c = 0; c < uart_rx_pkg::NUM_CH; c++) begin
      rxd[c] = 1'b1;
    end
    load_cases();
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    if (load_ok) begin
      run_cases();
    end else begin
      $display("could not open the case file bench/uart_rx_cases.txt");
    end
    repeat (4) @(negedge clk);
    report_result();
  end

endmodule

// ==== bench/uart_rx_array_checker.sv ====
// watches the axi4-lite responses of the dut and compares reads with words built from the case file
`timescale 1ns/100ps

module uart_rx_array_checker (
  input logic                   clk,
  input logic                   rst,
  input uart_rx_pkg::axil_req_t axil_req,
  input uart_rx_pkg::axil_rsp_t axil_rsp
);

  uart_rx_pkg::axil_data_t exp_q [$];
  uart_rx_pkg::axil_data_t exp_w;
  int n_tests = 0;
  int n_errors = 0;

  // expected status words, one per read, in file order
  initial begin
    int fd;
    int op, ch, d, st, n;
    string line;
    uart_rx_pkg::uart_byte_t last [uart_rx_pkg::NUM_CH];
    uart_rx_pkg::axil_data_t w;
    foreach (last[c]) last[c] = '0;
    fd = $fopen("bench/uart_rx_cases.txt", "r");
    if (fd == 0) begin
      $display("checker could not open the case file");
      n_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ($sscanf(line, "%d %d %h %d %d", op, ch, d, st, n) == 5) begin
          if (n > 0) begin
            last[ch] = uart_rx_pkg::uart_byte_t'(d);
          end
          // data 7..0, valid 8, ferr 9, overrun 10
          // flags start clear since every case ends in a read
          w = {21'b0, n > 1, n > 0 && st == 0, n > 0, last[ch]};
          exp_q.push_back(w);
        end
      end
      $fclose(fd);
    end
  end

  always @(posedge clk) begin
    if (!rst && axil_rsp.rvalid && axil_req.rready) begin
      if (exp_q.size() == 0) begin
        $display("read response %0d arrived with no case left to compare", n_tests + 1);
        n_errors++;
      end else begin
        exp_w = exp_q.pop_front();
        n_tests++;
        if (axil_rsp.rdata !== exp_w) begin
          $display("[ERROR] test %0d rdata: got 0x%08h, expected 0x%08h",
                   n_tests, axil_rsp.rdata, exp_w);
          n_errors++;
        end else if (axil_rsp.rresp !== uart_rx_pkg::RESP_OKAY) begin
          $display("[ERROR] test %0d rresp: got 0x%0h, expected 0x%0h",
                   n_tests, axil_rsp.rresp, uart_rx_pkg::RESP_OKAY);
          n_errors++;
        end else begin
          $display("test %0d ok, rdata 0x%08h", n_tests, exp_w);
        end
      end
    end
    // every write is refused
    if (!rst && axil_rsp.bvalid && axil_req.bready && axil_rsp.bresp !== uart_rx_pkg::RESP_SLVERR) begin
      $display("[ERROR] bresp: got 0x%0h, expected 0x%0h", axil_rsp.bresp, uart_rx_pkg::RESP_SLVERR);
      n_errors++;
    end
  end

endmodule

// ==== bench/uart_rx_array_props.sv ====
// concurrent checks on receiver strobes and the axi4-lite read handshake, bound into the dut top
`timescale 1ns/100ps

module uart_rx_array_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   frame_valid [uart_rx_pkg::NUM_CH],
  input uart_rx_pkg::axil_req_t axil_req,
  input uart_rx_pkg::axil_rsp_t axil_rsp
);

  // failed assertions so far, read by the testbench top
  int n_fail = 0;

  // frame strobe is a single-cycle pulse
  for (genvar i = 0; i < uart_rx_pkg::NUM_CH; i++) begin : g_strobe
    a_strobe_one_cycle : assert property (
      @(posedge clk) disable iff (rst) frame_valid[i] |=> !frame_valid[i]
    ) else begin
      $error("frame_valid of channel %0d held for more than one cycle", i);
      n_fail++;
    end
  end

  // read data stays put until taken
  a_rvalid_hold : assert property (
    @(posedge clk) disable iff (rst)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata)
  ) else begin
    $error("rvalid dropped or rdata changed before rready");
    n_fail++;
  end

  // only one read outstanding
  a_no_ar_during_r : assert property (
    @(posedge clk) disable iff (rst) axil_rsp.rvalid |-> !axil_rsp.arready
  ) else begin
    $error("arready high while a read response is pending");
    n_fail++;
  end

endmodule

// ==== src/uart_rx_array.sv ====
// top of the four-channel uart receive array; line conditioner, receivers and axi4-lite register bank
`timescale 1ns/100ps

module uart_rx_array (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rxd [uart_rx_pkg::NUM_CH],
  input  uart_rx_pkg::axil_req_t axil_req,
  output uart_rx_pkg::axil_rsp_t axil_rsp
);

  // filtered lines into the receivers
  logic                   rxd_clean [uart_rx_pkg::NUM_CH];
  // received characters into the register bank
  uart_rx_pkg::rx_frame_t frame [uart_rx_pkg::NUM_CH];
  logic                   frame_valid [uart_rx_pkg::NUM_CH];

  rx_line_sync i_rx_line_sync (
    .clk       (clk),
    .rst       (rst),
    .rxd       (rxd),
    .rxd_clean (rxd_clean)
  );

  // one receiver per channel
  for (genvar i = 0; i < uart_rx_pkg::NUM_CH; i++) begin : g_ch
    uart_rx i_uart_rx (
      .clk         (clk),
      .rst         (rst),
      .rxd         (rxd_clean[i]),
      .frame       (frame[i]),
      .frame_valid (frame_valid[i])
    );
  end

  rx_axil_regs i_rx_axil_regs (
    .clk         (clk),
    .rst         (rst),
    .frame       (frame),
    .frame_valid (frame_valid),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp)
  );

endmodule

// ==== src/rx_axil_regs.sv ====
// per-channel holding registers with status flags, read out over an axi4-lite slave port
`timescale 1ns/100ps

module rx_axil_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  uart_rx_pkg::rx_frame_t frame [uart_rx_pkg::NUM_CH],
  input  logic                   frame_valid [uart_rx_pkg::NUM_CH],
  input  uart_rx_pkg::axil_req_t axil_req,
  output uart_rx_pkg::axil_rsp_t axil_rsp
);

  // channel registers
  uart_rx_pkg::uart_byte_t data_q [uart_rx_pkg::NUM_CH];
  logic                    valid_q [uart_rx_pkg::NUM_CH];
  logic                    ferr_q [uart_rx_pkg::NUM_CH];
  logic                    ovr_q [uart_rx_pkg::NUM_CH];
  uart_rx_pkg::axil_data_t status [uart_rx_pkg::NUM_CH];

  // read side
  uart_rx_pkg::rd_state_t  rd_state;
  uart_rx_pkg::axil_data_t rdata_q;
  uart_rx_pkg::axil_resp_t rresp_q;
  uart_rx_pkg::axil_addr_t ar_idx;
  logic [uart_rx_pkg::CH_W-1:0] ar_ch;
  logic                    ar_ok;
  logic                    ar_fire;

  // write side
  uart_rx_pkg::wr_state_t  wr_state;
  logic                    aw_seen;
  logic                    w_seen;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    wr_done;

  // status word per channel
  always_comb begin
    for (int c = 0; c < uart_rx_pkg::NUM_CH; c++) begin
      status[c]                       = '0;
      status[c][7:0]                  = data_q[c];
      status[c][uart_rx_pkg::ST_VALID] = valid_q[c];
      status[c][uart_rx_pkg::ST_FERR]  = ferr_q[c];
      status[c][uart_rx_pkg::ST_OVR]   = ovr_q[c];
    end
  end

  // address decode, word index plus range check
  assign ar_idx  = uart_rx_pkg::axil_addr_t'(axil_req.araddr / uart_rx_pkg::REG_STRIDE);
  assign ar_ch   = ar_idx[uart_rx_pkg::CH_W-1:0];
  assign ar_ok   = int'(axil_req.araddr) < uart_rx_pkg::NUM_CH * uart_rx_pkg::REG_STRIDE;
  assign ar_fire = (rd_state == uart_rx_pkg::RD_IDLE) && axil_req.arvalid;

  // frame strobe wins over a clearing read in the same cycle
  always_ff @(posedge clk) begin
    for (int c = 0; c < uart_rx_pkg::NUM_CH; c++) begin
      if (rst) begin
        valid_q[c] <= 1'b0;
        ferr_q[c]  <= 1'b0;
        ovr_q[c]   <= 1'b0;
      end else if (frame_valid[c]) begin
        valid_q[c] <= 1'b1;
        ferr_q[c]  <= frame[c].ferr;
        // a read of this channel right now takes the old word, so no overrun
        ovr_q[c]   <= valid_q[c] && !(ar_fire && ar_ok && ar_ch == c[uart_rx_pkg::CH_W-1:0]);
      end else if (ar_fire && ar_ok && ar_ch == c[uart_rx_pkg::CH_W-1:0]) begin
        valid_q[c] <= 1'b0;
        ferr_q[c]  <= 1'b0;
        ovr_q[c]   <= 1'b0;
      end
      if (frame_valid[c]) begin
        data_q[c] <= frame[c].data;
      end
    end
  end

  // read fsm, one cycle from address to data
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= uart_rx_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        uart_rx_pkg::RD_IDLE: begin
          if (ar_fire) begin
            rd_state <= uart_rx_pkg::RD_DATA;
          end
        end
        uart_rx_pkg::RD_DATA: begin
          if (axil_req.rready) begin
            rd_state <= uart_rx_pkg::RD_IDLE;
          end
        end
        default: begin
          rd_state <= uart_rx_pkg::RD_IDLE;
        end
      endcase
    end
    if (ar_fire) begin
      rdata_q <= ar_ok ? status[ar_ch] : '0;
      rresp_q <= ar_ok ? uart_rx_pkg::RESP_OKAY : uart_rx_pkg::RESP_SLVERR;
    end
  end

  // writes are refused, address and data may come in any order
  assign aw_fire = (wr_state == uart_rx_pkg::WR_IDLE) && !aw_seen && axil_req.awvalid;
  assign w_fire  = (wr_state == uart_rx_pkg::WR_IDLE) && !w_seen && axil_req.wvalid;
  assign wr_done = (aw_seen || aw_fire) && (w_seen || w_fire);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= uart_rx_pkg::WR_IDLE;
      aw_seen  <= 1'b0;
      w_seen   <= 1'b0;
    end else if (wr_state == uart_rx_pkg::WR_IDLE) begin
      if (wr_done) begin
        wr_state <= uart_rx_pkg::WR_RESP;
        aw_seen  <= 1'b0;
        w_seen   <= 1'b0;
      end else begin
        aw_seen <= aw_seen || aw_fire;
        w_seen  <= w_seen || w_fire;
      end
    end else if (axil_req.bready) begin
      wr_state <= uart_rx_pkg::WR_IDLE;
    end
  end

  // slave outputs
  always_comb begin
    axil_rsp.awready = (wr_state == uart_rx_pkg::WR_IDLE) && !aw_seen;
    axil_rsp.wready  = (wr_state == uart_rx_pkg::WR_IDLE) && !w_seen;
    axil_rsp.bvalid  = (wr_state == uart_rx_pkg::WR_RESP);
    axil_rsp.bresp   = uart_rx_pkg::RESP_SLVERR;
    axil_rsp.arready = (rd_state == uart_rx_pkg::RD_IDLE);
    axil_rsp.rvalid  = (rd_state == uart_rx_pkg::RD_DATA);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

// ==== src/uart_rx.sv ====
// 8N1 serial receiver with mid-bit sampling and stop-bit check; one instance per channel
`timescale 1ns/100ps

module uart_rx (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rxd,
  output uart_rx_pkg::rx_frame_t frame,
  output logic                  frame_valid
);

  uart_rx_pkg::rx_state_t  state_q;
  uart_rx_pkg::rx_state_t  state_d;
  uart_rx_pkg::cnt_t       cnt_q;
  uart_rx_pkg::cnt_t       cnt_d;
  logic [2:0]              bit_q;
  logic [2:0]              bit_d;
  uart_rx_pkg::uart_byte_t shift_q;
  uart_rx_pkg::uart_byte_t shift_d;
  uart_rx_pkg::rx_frame_t  frame_d;
  logic                    valid_d;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    bit_d   = bit_q;
    shift_d = shift_q;
    frame_d = frame;
    valid_d = 1'b0;
    case (state_q)
      uart_rx_pkg::IDLE: begin
        cnt_d = '0;
        bit_d = '0;
        // falling edge of a possible start bit
        if (!rxd) begin
          state_d = uart_rx_pkg::START;
        end
      end
      uart_rx_pkg::START: begin
        if (rxd) begin
          // glitch, not a start bit
          state_d = uart_rx_pkg::IDLE;
        end else if (cnt_q == uart_rx_pkg::HALF_LAST) begin
          // now at the middle of the start bit
          cnt_d   = '0;
          state_d = uart_rx_pkg::RECV;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      uart_rx_pkg::RECV: begin
        if (cnt_q == uart_rx_pkg::BIT_LAST) begin
          cnt_d = '0;
          // lsb first, so shift in from the top
          shift_d = {rxd, shift_q[7:1]};
          bit_d   = bit_q + 1'b1;
          if (bit_q == 3'd7) begin
            state_d = uart_rx_pkg::STOP;
          end
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      uart_rx_pkg::STOP: begin
        if (cnt_q == uart_rx_pkg::BIT_LAST) begin
          cnt_d = '0;
          // stop bit must be high
          frame_d.data = shift_q;
          frame_d.ferr = !rxd;
          valid_d      = 1'b1;
          state_d      = uart_rx_pkg::IDLE;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      default: begin
        state_d = uart_rx_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= uart_rx_pkg::IDLE;
      cnt_q       <= '0;
      bit_q       <= '0;
      frame_valid <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      bit_q       <= bit_d;
      frame_valid <= valid_d;
    end
    // payload only, qualified by frame_valid
    shift_q <= shift_d;
    frame   <= frame_d;
  end

endmodule

// ==== src/rx_line_sync.sv ====
// brings every asynchronous serial line into the clock domain and filters out one-cycle glitches
`timescale 1ns/100ps

module rx_line_sync (
  input  logic clk,
  input  logic rst,
  input  logic rxd [uart_rx_pkg::NUM_CH],
  output logic rxd_clean [uart_rx_pkg::NUM_CH]
);

  // per line sample pipe, taps 0 and 1 are the synchronizer pair
  logic [2:0] pipe_q [uart_rx_pkg::NUM_CH];

  always_ff @(posedge clk) begin
    for (int i = 0; i < uart_rx_pkg::NUM_CH; i++) begin
      if (rst) begin
        // line idles high, so preset everything to 1
        pipe_q[i]    <= 3'b111;
        rxd_clean[i] <= 1'b1;
      end else begin
        pipe_q[i] <= {pipe_q[i][1:0], rxd[i]};
        // registered 2 of 3 vote
        rxd_clean[i] <= (pipe_q[i][0] & pipe_q[i][1]) |
                        (pipe_q[i][1] & pipe_q[i][2]) |
                        (pipe_q[i][0] & pipe_q[i][2]);
      end
    end
  end

endmodule

// ==== src/uart_rx_pkg.sv ====
// shared constants, register map and types of the uart receive array; compile before all modules
package uart_rx_pkg;

  // channel count and index width
  localparam int NUM_CH = 4;
  localparam int CH_W   = $clog2(NUM_CH);

  // clock cycles per serial bit
  localparam int WAIT_DIV = 16;
  localparam int CNT_W    = $clog2(WAIT_DIV);

  // bit-period counter and its two terminal counts
  typedef logic [CNT_W-1:0] cnt_t;
  localparam cnt_t HALF_LAST = cnt_t'(WAIT_DIV / 2 - 1);
  localparam cnt_t BIT_LAST  = cnt_t'(WAIT_DIV - 1);

  // register map, one status word per channel
  localparam int REG_STRIDE = 4;
  localparam int ADDR_W     = 4;
  localparam int ST_VALID   = 8;
  localparam int ST_FERR    = 9;
  localparam int ST_OVR     = 10;

  typedef logic [7:0]        uart_byte_t;
  typedef logic [ADDR_W-1:0] axil_addr_t;
  typedef logic [31:0]       axil_data_t;
  typedef logic [1:0]        axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // one received character
  typedef struct packed {
    uart_byte_t data;
    logic       ferr;
  } rx_frame_t;

  // master side of the axi4-lite port
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // slave side of the axi4-lite port
  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_t;

  typedef enum logic [1:0] {IDLE, START, RECV, STOP} rx_state_t;
  typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;
  typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;

endpackage
